//--- mul_cluster.f
rv32m_pkg.sv
mul_issue_dispatch.sv
fu_mult.sv
mul_writeback_arbiter.sv
mul_cluster.sv
mul_cluster_checker.sv
mul_cluster_tb.sv

//--- mul_cluster_tb.sv
module mul_cluster_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'hd5f1_1f16;
    localparam int N_T2 = 4 * (16 + 8);
    localparam int N_T3 = 16;
    localparam int N_T4 = 1;
    localparam int N_T5 = 6;
    localparam int N_T6 = 200;
    localparam int TOTAL_ISSUES = N_T2 + N_T3 + N_T4 + N_T5 + N_T6;
    localparam int WATCHDOG_CYCLES = TOTAL_ISSUES * 40 + 200;

    logic clk;
    logic rst;
    logic issue_valid;
    logic issue_ready;
    rv32m_pkg::mul_issue_t issue;
    logic wb_valid;
    logic wb_ready;
    rv32m_pkg::mul_result_t wb;

    int chk_errors;
    int pending;
    int wb_count;
    int tb_errors = 0;
    int issued = 0;
    int tests_run = 0;
    int stall_cycles = 0;
    int stall_left = 0;
    bit rand_ready = 1'b0;
    logic [31:0] op_state = SEED;
    logic [31:0] rdy_state = SEED ^ 32'h5a5a_5a5a; // Separate stream for wb_ready
    logic [rv32m_pkg::PHYS_REG_BITS-1:0] recent_tags [8];
    logic [31:0] corners [4] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};

    mul_cluster mul_cluster_i (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue(issue),
        .issue_ready(issue_ready),
        .wb_valid(wb_valid),
        .wb(wb),
        .wb_ready(wb_ready)
    );

    mul_cluster_checker checker_i (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue_ready(issue_ready),
        .issue(issue),
        .wb_valid(wb_valid),
        .wb_ready(wb_ready),
        .wb(wb),
        .errors(chk_errors),
        .pending(pending),
        .wb_count(wb_count)
    );

    function automatic logic [31:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    function automatic int total_errors();
        return tb_errors + chk_errors;
    endfunction

    // A tag must differ from everything that can still be in flight
    function automatic logic [rv32m_pkg::PHYS_REG_BITS-1:0] pick_tag();
        logic [31:0] r;
        logic [rv32m_pkg::PHYS_REG_BITS-1:0] t;
        bit clash;
        do begin
            r = lcg_next(op_state);
            t = r[16 +: rv32m_pkg::PHYS_REG_BITS];
            clash = 1'b0;
            foreach (recent_tags[i]) begin
                if (recent_tags[i] == t) begin
                    clash = 1'b1;
                end
            end
        end while (clash);
        for (int i = 7; i > 0; i--) begin
            recent_tags[i] = recent_tags[i-1];
        end
        recent_tags[0] = t;
        return t;
    endfunction

    // Called just after a falling edge, returns just after the edge that follows the transfer
    task automatic send_op(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        r = lcg_next(op_state);
        issue.rs1_v = a;
        issue.rs2_v = b;
        issue.instr.raw = {rv32m_pkg::funct7_muldiv, r[28:24], r[23:19], f3, r[18:14],
                           rv32m_pkg::opcode_op};
        issue.tag = pick_tag();
        issue_valid = 1'b1;
        while (!issue_ready) @(negedge clk);
        @(negedge clk);
        issued++;
    endtask

    task automatic drain();
        issue_valid = 1'b0;
        while (pending != 0 || wb_valid) @(negedge clk);
        assert (wb_count == issued) else begin
            tb_errors++;
            $display("MISMATCH at %0t: wb_count expected %0d actual %0d", $time, issued, wb_count);
        end
    endtask

    task automatic set_ready(input int low_cycles, input bit rnd);
        @(posedge clk);
        stall_left = low_cycles;
        rand_ready = rnd;
        @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, total_errors() - errs_before);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // wb_ready is low while stall_left runs down, then random or high
    initial begin
        logic [31:0] r;
        wb_ready = 1'b1;
        forever begin
            @(negedge clk);
            r = lcg_next(rdy_state);
            if (stall_left > 0) begin
                wb_ready = 1'b0;
                stall_left--;
            end else if (rand_ready) begin
                wb_ready = r[31] | r[30];
            end else begin
                wb_ready = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && issue_valid && !issue_ready) begin
            stall_cycles <= stall_cycles + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with %0d results pending", WATCHDOG_CYCLES,
                 pending);
        $display("sim failed");
        $finish;
    end

    initial begin
        int errs;
        int stall_before;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        foreach (recent_tags[i]) begin
            recent_tags[i] = '1;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errs = total_errors();
        @(negedge clk);
        assert (issue_ready === 1'b1) else begin
            tb_errors++;
            $display("MISMATCH at %0t: issue_ready expected 1 actual %b", $time, issue_ready);
        end
        assert (wb_valid === 1'b0) else begin
            tb_errors++;
            $display("MISMATCH at %0t: wb_valid expected 0 actual %b", $time, wb_valid);
        end
        finish_test("reset state", errs);

        errs = total_errors();
        for (int f = 0; f < 4; f++) begin
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    send_op(3'(f), corners[i], corners[j]);
                end
            end
            repeat (8) begin
                a = lcg_next(op_state);
                b = lcg_next(op_state);
                send_op(3'(f), a, b);
            end
        end
        drain();
        finish_test("funct3 results", errs);

        errs = total_errors();
        repeat (N_T3) begin
            r = lcg_next(op_state);
            a = lcg_next(op_state);
            b = lcg_next(op_state);
            send_op({1'b0, r[31:30]}, a, b);
        end
        drain();
        finish_test("tag round trip", errs);

        errs = total_errors();
        set_ready(12, 1'b0); // Long enough to stall the single result
        send_op(rv32m_pkg::mul_f3_mulh, 32'h8000_0000, 32'h7fff_ffff);
        drain();
        finish_test("writeback stall", errs);

        errs = total_errors();
        stall_before = stall_cycles;
        set_ready(40, 1'b0);
        repeat (N_T5) begin
            a = lcg_next(op_state);
            b = lcg_next(op_state);
            send_op(rv32m_pkg::mul_f3_mulhu, a, b);
        end
        drain();
        assert (stall_cycles > stall_before) else begin
            tb_errors++;
            $display("issue_ready never fell while the lanes were full, at %0t", $time);
        end
        finish_test("lanes full", errs);

        errs = total_errors();
        set_ready(0, 1'b1);
        repeat (N_T6) begin
            r = lcg_next(op_state);
            if (r[29:28] == 2'b00) begin
                issue_valid = 1'b0;
                @(negedge clk);
            end
            a = lcg_next(op_state);
            b = lcg_next(op_state);
            send_op({1'b0, r[31:30]}, a, b);
        end
        drain();
        set_ready(0, 1'b0);
        finish_test("random traffic", errs);

        $display("%0d tests, %0d issued, %0d written back, %0d errors", tests_run, issued,
                 wb_count, total_errors());
        if (total_errors() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- mul_cluster_checker.sv
module mul_cluster_checker (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid,
    input  logic issue_ready,
    input  rv32m_pkg::mul_issue_t issue,
    input  logic wb_valid,
    input  logic wb_ready,
    input  rv32m_pkg::mul_result_t wb,
    output int errors,
    output int pending,
    output int wb_count
);
    timeunit 1ns;
    timeprecision 1ps;

    rv32m_pkg::mul_result_t exp_q [$];
    logic wb_fire_q;
    logic tag_found_q;
    logic [rv32m_pkg::PHYS_REG_BITS-1:0] tag_q;
    logic [31:0] exp_rd_q;
    logic [31:0] act_rd_q;
    logic stall_q;
    rv32m_pkg::mul_result_t wb_q;

    initial errors = 0;

    // Operands are widened to 64 bits as signed or unsigned by funct3
    function automatic logic [31:0] ref_mul(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0] ua;
        logic [63:0] ub;
        logic [63:0] p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        case (f3)
            rv32m_pkg::mul_f3_mulhsu: p = sa * $signed(ub);
            rv32m_pkg::mul_f3_mulhu:  p = ua * ub;
            default:                  p = sa * sb; // MUL and MULH
        endcase
        return (f3 == rv32m_pkg::mul_f3_mul) ? p[31:0] : p[63:32];
    endfunction

    // Transfers seen at one edge are checked by the assertions at the next
    always @(posedge clk) begin
        rv32m_pkg::mul_result_t e;
        int idx;
        if (rst) begin
            exp_q.delete();
            wb_fire_q <= 1'b0;
            stall_q <= 1'b0;
            pending <= 0;
            wb_count <= 0;
        end else begin
            if (issue_valid && issue_ready) begin
                e.rd_v = ref_mul(issue.instr.r.funct3, issue.rs1_v, issue.rs2_v);
                e.tag = issue.tag;
                exp_q.push_back(e);
            end
            idx = -1;
            if (wb_valid && wb_ready) begin
                wb_count <= wb_count + 1; // Every writeback transfer, known tag or not
                foreach (exp_q[i]) begin
                    if (idx < 0 && exp_q[i].tag == wb.tag) begin
                        idx = i;
                    end
                end
            end
            wb_fire_q <= wb_valid && wb_ready;
            tag_found_q <= (idx >= 0);
            tag_q <= wb.tag;
            act_rd_q <= wb.rd_v;
            exp_rd_q <= (idx >= 0) ? exp_q[idx].rd_v : 32'h0;
            if (idx >= 0) begin
                exp_q.delete(idx); // Each tag may come back only once
            end
            pending <= exp_q.size();
            stall_q <= wb_valid && !wb_ready;
            wb_q <= wb;
        end
    end

    a_tag_known: assert property (
        @(posedge clk) disable iff (rst)
        wb_fire_q |-> tag_found_q
    ) else begin
        errors++;
        $display("%0t: writeback carried tag %0d that is not outstanding", $time, $sampled(tag_q));
    end

    a_rd_match: assert property (
        @(posedge clk) disable iff (rst)
        wb_fire_q && tag_found_q |-> act_rd_q == exp_rd_q
    ) else begin
        errors++;
        $display("MISMATCH at %0t: wb.rd_v tag %0d expected %h actual %h", $time,
                 $sampled(tag_q), $sampled(exp_rd_q), $sampled(act_rd_q));
    end

    a_valid_held: assert property (
        @(posedge clk) disable iff (rst)
        stall_q |-> wb_valid
    ) else begin
        errors++;
        $display("%0t: wb_valid dropped before wb_ready accepted the result", $time);
    end

    a_wb_held: assert property (
        @(posedge clk) disable iff (rst)
        stall_q && wb_valid |-> wb == wb_q
    ) else begin
        errors++;
        $display("MISMATCH at %0t: wb expected %h actual %h", $time, $sampled(wb_q), $sampled(wb));
    end

endmodule

//--- mul_cluster.sv
module mul_cluster (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid,
    input  rv32m_pkg::mul_issue_t issue,
    output logic issue_ready,
    output logic wb_valid,
    output rv32m_pkg::mul_result_t wb,
    input  logic wb_ready
);

    logic [rv32m_pkg::NUM_MUL_LANES-1:0] lane_start;
    logic [rv32m_pkg::NUM_MUL_LANES-1:0] lane_done;
    logic [rv32m_pkg::NUM_MUL_LANES-1:0] lane_grant;
    rv32m_pkg::mul_result_t lane_result [rv32m_pkg::NUM_MUL_LANES];

    mul_issue_dispatch dispatch_i (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue(issue),
        .issue_ready(issue_ready),
        .lane_start(lane_start),
        .lane_release(lane_grant) // A granted lane is free again next cycle
    );

    for (genvar i = 0; i < rv32m_pkg::NUM_MUL_LANES; i++) begin : g_lane
        fu_mult fu_mult_i (
            .clk(clk),
            .rst(rst),
            .start(lane_start[i]),
            .issue(issue),
            .hold(!lane_grant[i]),
            .done(lane_done[i]),
            .result(lane_result[i])
        );
    end

    mul_writeback_arbiter arbiter_i (
        .clk(clk),
        .rst(rst),
        .lane_done(lane_done),
        .lane_result(lane_result),
        .lane_grant(lane_grant),
        .wb_valid(wb_valid),
        .wb(wb),
        .wb_ready(wb_ready)
    );

    // A lane holding a finished result is never chosen for a new start
    a_start_not_done: assert property (
        @(posedge clk) disable iff (rst)
        (lane_start & lane_done) == '0
    ) else $error("start %b to a lane with a pending result %b", lane_start, lane_done);

endmodule

//--- mul_writeback_arbiter.sv
module mul_writeback_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic [rv32m_pkg::NUM_MUL_LANES-1:0] lane_done,
    input  rv32m_pkg::mul_result_t lane_result [rv32m_pkg::NUM_MUL_LANES],
    output logic [rv32m_pkg::NUM_MUL_LANES-1:0] lane_grant,
    output logic wb_valid,
    output rv32m_pkg::mul_result_t wb,
    input  logic wb_ready
);

    logic [rv32m_pkg::LANE_IDX_BITS-1:0] last_win;
    logic [rv32m_pkg::LANE_IDX_BITS-1:0] win_idx;
    logic win_found;
    logic can_load;

    // The output register takes a new result when empty or draining now
    assign can_load = !wb_valid || wb_ready;

    // Round-robin search, the lane right after the last winner comes last in
    // the loop so it has the highest priority
    always_comb begin
        int cand;
        win_idx = last_win;
        win_found = 1'b0;
        for (int k = rv32m_pkg::NUM_MUL_LANES; k >= 1; k--) begin
            cand = (int'(last_win) + k) % rv32m_pkg::NUM_MUL_LANES;
            if (lane_done[cand]) begin
                win_idx = (rv32m_pkg::LANE_IDX_BITS)'(cand);
                win_found = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rv32m_pkg::NUM_MUL_LANES; i++) begin
            lane_grant[i] = can_load && win_found && (win_idx == i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            last_win <= '0;
        end else if (can_load) begin
            wb_valid <= win_found; // Empty stage stays empty without a winner
            if (win_found) begin
                last_win <= win_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_load && win_found) begin
            wb <= lane_result[win_idx];
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(lane_grant) && ((lane_grant & ~lane_done) == '0)
    ) else $error("bad grant %b for done %b", lane_grant, lane_done);

    a_wb_hold: assert property (
        @(posedge clk) disable iff (rst)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb)
    ) else $error("wb changed while stalled by wb_ready");

endmodule

//--- fu_mult.sv
module fu_mult (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  rv32m_pkg::mul_issue_t issue,
    input  logic hold,
    output logic done,
    output rv32m_pkg::mul_result_t result
);

    logic run;
    logic last_step;
    logic [$clog2(rv32m_pkg::MUL_CYCLES)-1:0] step;
    logic [2:0] f3_q;
    logic [rv32m_pkg::PHYS_REG_BITS-1:0] tag_q;

    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [32:0] mcand;
    logic [rv32m_pkg::MUL_CYCLES*rv32m_pkg::MUL_DIGIT_BITS-1:0] mplier;

    logic signed [rv32m_pkg::MUL_DIGIT_BITS:0] digit;
    logic signed [32+rv32m_pkg::MUL_DIGIT_BITS+1:0] pp;
    logic signed [65:0] pp_ext;
    logic [65:0] acc;

    // Operand extension for the four multiply flavours
    always_comb begin
        case (issue.instr.r.funct3)
            rv32m_pkg::mul_f3_mul, rv32m_pkg::mul_f3_mulh: begin
                a_ext = {issue.rs1_v[31], issue.rs1_v};
                b_ext = {issue.rs2_v[31], issue.rs2_v};
            end
            rv32m_pkg::mul_f3_mulhsu: begin
                a_ext = {issue.rs1_v[31], issue.rs1_v};
                b_ext = {1'b0, issue.rs2_v};
            end
            rv32m_pkg::mul_f3_mulhu: begin
                a_ext = {1'b0, issue.rs1_v};
                b_ext = {1'b0, issue.rs2_v};
            end
            default: begin
                a_ext = {issue.rs1_v[31], issue.rs1_v};
                b_ext = {issue.rs2_v[31], issue.rs2_v};
            end
        endcase
    end

    assign last_step = (step == rv32m_pkg::MUL_CYCLES - 1);

    // The top digit carries the sign of the extended multiplier
    assign digit = last_step
        ? {mplier[rv32m_pkg::MUL_DIGIT_BITS-1], mplier[rv32m_pkg::MUL_DIGIT_BITS-1:0]}
        : {1'b0, mplier[rv32m_pkg::MUL_DIGIT_BITS-1:0]};

    assign pp = mcand * digit;
    assign pp_ext = pp;

    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            if (start) begin
                run <= 1'b1;
                step <= '0;
            end else if (run) begin
                step <= step + 1'b1;
                if (last_step) begin
                    run <= 1'b0;
                    done <= 1'b1;
                end
            end
            if (done && !hold) begin
                done <= 1'b0; // Granted, the result leaves this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= a_ext;
            mplier <= {{(rv32m_pkg::MUL_CYCLES*rv32m_pkg::MUL_DIGIT_BITS-33){b_ext[32]}}, b_ext};
            acc <= '0;
            f3_q <= issue.instr.r.funct3;
            tag_q <= issue.tag;
        end else if (run) begin
            acc <= acc + (pp_ext <<< (step * rv32m_pkg::MUL_DIGIT_BITS));
            mplier <= mplier >> rv32m_pkg::MUL_DIGIT_BITS;
        end
    end

    always_comb begin
        result.tag = tag_q;
        case (f3_q)
            rv32m_pkg::mul_f3_mul: result.rd_v = acc[31:0];
            default:               result.rd_v = acc[63:32]; // All high variants
        endcase
    end

    a_start_idle: assert property (
        @(posedge clk) disable iff (rst)
        start |-> !run && !done
    ) else $error("start while the lane is busy");

    a_done_latency: assert property (
        @(posedge clk) disable iff (rst)
        start |-> ##(rv32m_pkg::MUL_CYCLES + 1) $rose(done)
    ) else $error("done did not rise MUL_CYCLES after start");

    // Until the grant comes the result must not move
    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        done && hold |=> done && $stable(result)
    ) else $error("lane result changed under hold");

endmodule

//--- mul_issue_dispatch.sv
module mul_issue_dispatch (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid,
    input  rv32m_pkg::mul_issue_t issue,
    output logic issue_ready,
    output logic [rv32m_pkg::NUM_MUL_LANES-1:0] lane_start,
    input  logic [rv32m_pkg::NUM_MUL_LANES-1:0] lane_release
);

    logic [rv32m_pkg::NUM_MUL_LANES-1:0] busy;
    logic [rv32m_pkg::LANE_IDX_BITS-1:0] sel_idx;
    logic sel_found;
    logic fire;

    // Priority encoder, the lowest idle lane overwrites the others
    always_comb begin
        sel_idx = '0;
        sel_found = 1'b0;
        for (int i = rv32m_pkg::NUM_MUL_LANES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                sel_idx = (rv32m_pkg::LANE_IDX_BITS)'(i);
                sel_found = 1'b1;
            end
        end
    end

    assign issue_ready = sel_found;
    assign fire = issue_valid && issue_ready;

    always_comb begin
        for (int i = 0; i < rv32m_pkg::NUM_MUL_LANES; i++) begin
            lane_start[i] = fire && (sel_idx == i);
        end
    end

    // A lane is busy from its start edge until the arbiter grants its result
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            busy <= (busy | lane_start) & ~lane_release;
        end
    end

    a_issue_is_mul: assert property (
        @(posedge clk) disable iff (rst)
        fire |-> (issue.instr.r.opcode == rv32m_pkg::opcode_op)
              && (issue.instr.r.funct7 == rv32m_pkg::funct7_muldiv)
              && (issue.instr.r.funct3 < 3'd4)
    ) else $error("issue accepted with a non-multiply instruction %h", issue.instr.raw);

    a_start_to_idle: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(lane_start) && ((lane_start & busy) == '0)
    ) else $error("start %b sent to a busy lane, busy %b", lane_start, busy);

    // The arbiter may only release a lane that this dispatcher started
    a_release_busy: assert property (
        @(posedge clk) disable iff (rst)
        (lane_release & ~busy) == '0
    ) else $error("release %b of an idle lane, busy %b", lane_release, busy);

endmodule

//--- rv32m_pkg.sv
package rv32m_pkg;

    localparam int NUM_MUL_LANES = 2;
    localparam int LANE_IDX_BITS = 1;

    // Cycles from the start edge of a lane to its done
    localparam int MUL_CYCLES = 4;
    localparam int MUL_DIGIT_BITS = 9; // Four digits of 9 bits cover a 33-bit operand

    localparam int PHYS_REG_BITS = 6;

    localparam logic [2:0] mul_f3_mul = 3'b000;
    localparam logic [2:0] mul_f3_mulh = 3'b001;
    localparam logic [2:0] mul_f3_mulhsu = 3'b010;
    localparam logic [2:0] mul_f3_mulhu = 3'b011;

    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_rtype_t;

    // The same instruction word seen raw or split into R-type fields
    typedef union packed {
        logic [31:0] raw;
        rv_rtype_t r;
    } rv_instr_t;

    typedef struct packed {
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
        rv_instr_t instr;
        logic [PHYS_REG_BITS-1:0] tag; // Destination physical register
    } mul_issue_t;

    typedef struct packed {
        logic [31:0] rd_v;
        logic [PHYS_REG_BITS-1:0] tag;
    } mul_result_t;

endpackage
